// File: tests/fetch_stim.txt
# m <addr hex> <word hex>               memory image, other words keep the fill pattern
# e <cycle dec> <kind> <value hex>      event, cycle counted from reset release
# kinds: enable level, jump target, trap mtvec, mret mepc, sysrst unused value
m 00000100 00a00093
m 00000104 00108113
m 00000108 00210193
m 0000010c 0031a023
m 00000110 0001a203
m 00000114 00420233
m 00000400 00000517
m 00000404 00c50513
m 00000600 fff00293
m 00000900 30200073
m 00000a00 34202373
# jump, then a long stall
e 40 jump 00000400
e 60 enable 0
e 66 enable 1
# unaligned jump target
e 80 jump 00000602
# all three at once, mepc wins
e 100 jump 00000700
e 100 trap 00000800
e 100 mret 00000900
# trap over jump
e 120 trap 00000a00
e 120 jump 00000b00
e 140 jump 00000c04
e 160 sysrst 00000000
# nine redirects wrap the tag
e 180 jump 00000200
e 186 jump 00000240
e 192 trap 00000280
e 198 jump 000002c0
e 204 mret 00000300
e 210 jump 00000340
e 216 jump 00000380
e 222 jump 000003c0
e 228 jump 00000440

// File: ifetch.f
+incdir+common
common/ifetch_pkg.sv
fetch/fetch_ctrl.sv
fetch/fetch_addr.sv
fetch/fetch_data.sv
verilog/fetch_top.sv
tests/tb_fetch.sv

// File: Makefile
# Verilator build and run for the fetch front end

VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_fetch
FILELIST  := ifetch.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Pass only when the pass message shows up in the output
run: compile
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_fetch.sv
/*
 * Testbench for the fetch front end. Loads memory and timed events from the
 * stim file, drives them with random stalls, and checks every valid fetch
 * output against a reference pc and tag model.
 */

`timescale 1ns/1ps

`include "ifetch_consts.svh"

module tb_fetch
    import ifetch_pkg::*;
;

    localparam int    CLK_PERIOD = 40;
    localparam int    RESET_CYC  = 16;
    localparam int    TAIL_CYC   = 40;
    localparam int    MEM_WORDS  = 1024;
    localparam int    MIN_CHECKS = 100;
    localparam string STIM_FILE  = "tests/fetch_stim.txt";

    typedef enum logic [2:0] {
        EV_ENABLE,
        EV_JUMP,
        EV_TRAP,
        EV_MRET,
        EV_SYSRST
    } ev_kind_e;

    // One timed event from the stim file
    typedef struct packed {
        logic [15:0] cycle;
        ev_kind_e    kind;
        logic [31:0] value;
    } stim_event_t;

    logic        clk;
    logic        reset_n;
    logic        sys_reset_i;
    logic        enable_i;
    logic        jump_i;
    logic [31:0] jump_target_i;
    logic [31:0] mtvec_i;
    logic [31:0] mepc_i;
    logic        exception_i;
    logic        interrupt_ack_i;
    logic        mret_i;
    logic [31:0] instr_data_i = `IFETCH_NOP;
    logic [31:0] instr_addr_o;
    logic        jumping_o;
    fetch_out_t  fetch_o;

    logic [31:0]              mem [MEM_WORDS];
    stim_event_t              events[$];
    int                       stim_cycles = 0;
    logic                     stim_ready  = 1'b0;
    logic                     base_en     = 1'b1;
    logic                     trap_irq    = 1'b0;
    int                       stall_left  = 0;
    int                       errors      = 0;
    int                       checks      = 0;
    logic                     en_prev     = 1'b0;
    logic                     reset_checked = 1'b0;
    logic [31:0]              exp_pc      = `IFETCH_START_ADDR;
    logic [`IFETCH_TAG_W-1:0] exp_tag     = '0;

    fetch_top i_fetch_top (
        .clk             (clk),
        .reset_n         (reset_n),
        .sys_reset_i     (sys_reset_i),
        .enable_i        (enable_i),
        .jump_i          (jump_i),
        .jump_target_i   (jump_target_i),
        .mtvec_i         (mtvec_i),
        .mepc_i          (mepc_i),
        .exception_i     (exception_i),
        .interrupt_ack_i (interrupt_ack_i),
        .mret_i          (mret_i),
        .instr_data_i    (instr_data_i),
        .instr_addr_o    (instr_addr_o),
        .jumping_o       (jumping_o),
        .fetch_o         (fetch_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Word one clock after its address
    always @(posedge clk) begin
        instr_data_i <= mem[instr_addr_o[11:2]];
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus loading and driving
    //////////////////////////////////////////////////////////////////////

    // Background word, mixes every address bit
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    task automatic load_stim(output logic ok);
        int          fd;
        int          n;
        int          cyc;
        string       line;
        logic [63:0] rec;
        logic [63:0] kind_s;
        logic [31:0] a;
        logic [31:0] d;
        stim_event_t ev;
        ok = 1'b1;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(32'(i) << 2);
        end
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            ok = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                rec = '0;
                n = $fgets(line, fd);
                if (n > 0) begin
                    n = $sscanf(line, "%s", rec);
                end
                if (n > 0 && rec == "m") begin
                    n = $sscanf(line, "%s %h %h", rec, a, d);
                    mem[a[11:2]] = d;
                end else if (n > 0 && rec == "e") begin
                    n = $sscanf(line, "%s %d %s %h", rec, cyc, kind_s, d);
                    ev.cycle = 16'(cyc);
                    ev.value = d;
                    if (kind_s == "enable") ev.kind = EV_ENABLE;
                    else if (kind_s == "jump") ev.kind = EV_JUMP;
                    else if (kind_s == "trap") ev.kind = EV_TRAP;
                    else if (kind_s == "mret") ev.kind = EV_MRET;
                    else if (kind_s == "sysrst") ev.kind = EV_SYSRST;
                    else ok = 1'b0;
                    events.push_back(ev);
                    if (cyc + TAIL_CYC > stim_cycles) stim_cycles = cyc + TAIL_CYC;
                end else if (n > 0 && rec != "#") begin
                    ok = 1'b0;
                end
            end
            $fclose(fd);
        end
        if (events.size() == 0) ok = 1'b0;
    endtask

    // Request pulses last one cycle, targets stay
    task automatic apply_event(input stim_event_t ev);
        case (ev.kind)
            EV_ENABLE: base_en = ev.value[0];
            EV_JUMP: begin
                jump_target_i <= ev.value;
                jump_i        <= 1'b1;
            end
            EV_TRAP: begin
                mtvec_i <= ev.value;
                // Exception and interrupt share the trap path, take turns
                if (trap_irq) interrupt_ack_i <= 1'b1;
                else exception_i <= 1'b1;
                trap_irq = ~trap_irq;
            end
            EV_MRET: begin
                mepc_i <= ev.value;
                mret_i <= 1'b1;
            end
            default: sys_reset_i <= 1'b1;
        endcase
    endtask

    task automatic drive_cycle(input int cyc, inout int ev_idx);
        logic hit;
        hit = 1'b0;
        jump_i          <= 1'b0;
        exception_i     <= 1'b0;
        interrupt_ack_i <= 1'b0;
        mret_i          <= 1'b0;
        sys_reset_i     <= 1'b0;
        while (ev_idx < events.size() && events[ev_idx].cycle == 16'(cyc)) begin
            apply_event(events[ev_idx]);
            hit = 1'b1;
            ev_idx++;
        end
        // Event cycles always run enabled
        if (!base_en) begin
            enable_i <= 1'b0;
        end else if (hit) begin
            stall_left = 0;
            enable_i <= 1'b1;
        end else if (stall_left > 0) begin
            stall_left--;
            enable_i <= 1'b0;
        end else if ($urandom % 8 == 0) begin
            stall_left = int'($urandom % 3);
            enable_i <= 1'b0;
        end else begin
            enable_i <= 1'b1;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference model and checks
    //////////////////////////////////////////////////////////////////////

    // mepc over mtvec over jump target, low bits dropped
    function automatic logic [31:0] redirect_target();
        logic [31:0] t;
        if (mret_i) t = mepc_i;
        else if (exception_i || interrupt_ack_i) t = mtvec_i;
        else t = jump_target_i;
        return {t[31:2], 2'b00};
    endfunction

    task automatic check_reset_state();
        assert (instr_addr_o == `IFETCH_START_ADDR) else begin
            errors++;
            $display("ERROR %0t: reset address %h", $time, instr_addr_o);
        end
        assert (jumping_o == 1'b1) else begin
            errors++;
            $display("ERROR %0t: jumping low after reset", $time);
        end
        assert (fetch_o.instr == `IFETCH_NOP && fetch_o.pc == 32'd0 && fetch_o.tag == '1)
        else begin
            errors++;
            $display("ERROR %0t: reset output %h", $time, fetch_o);
        end
    endtask

    task automatic check_output();
        logic [31:0] exp_instr;
        exp_instr = mem[exp_pc[11:2]];
        checks++;
        assert (fetch_o.pc == exp_pc) else begin
            errors++;
            $display("ERROR %0t: pc %h, expected %h", $time, fetch_o.pc, exp_pc);
        end
        assert (fetch_o.instr == exp_instr) else begin
            errors++;
            $display("ERROR %0t: instr %h at pc %h, expected %h",
                     $time, fetch_o.instr, exp_pc, exp_instr);
        end
        assert (fetch_o.tag == exp_tag) else begin
            errors++;
            $display("ERROR %0t: tag %0d, expected %0d", $time, fetch_o.tag, exp_tag);
        end
        exp_pc = exp_pc + 32'd4;
    endtask

    // Sampled mid cycle, away from the driving edge
    always @(negedge clk) begin
        if (reset_n && !reset_checked) begin
            check_reset_state();
            reset_checked = 1'b1;
        end
        if (reset_n) begin
            // fetch_o moved on the last edge and is not stale
            if (en_prev && !jumping_o) begin
                check_output();
            end
            if (sys_reset_i) begin
                exp_pc = `IFETCH_START_ADDR;
            end else if (jump_i || exception_i || interrupt_ack_i || mret_i) begin
                exp_pc  = redirect_target();
                exp_tag = exp_tag + `IFETCH_TAG_W'(1);
            end
        end
        en_prev = reset_n && enable_i;
    end

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        logic load_ok;
        int   ev_idx;
        ev_idx = 0;
        void'($urandom(72));
        reset_n         <= 1'b0;
        sys_reset_i     <= 1'b0;
        enable_i        <= 1'b0;
        jump_i          <= 1'b0;
        jump_target_i   <= 32'd0;
        mtvec_i         <= 32'd0;
        mepc_i          <= 32'd0;
        exception_i     <= 1'b0;
        interrupt_ack_i <= 1'b0;
        mret_i          <= 1'b0;
        load_stim(load_ok);
        if (!load_ok) begin
            $display("Stimulus file could not be read or has a bad line");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            stim_ready = 1'b1;
            repeat (RESET_CYC) @(posedge clk);
            reset_n <= 1'b1;
            for (int cyc = 0; cyc < stim_cycles; cyc++) begin
                @(posedge clk);
                drive_cycle(cyc, ev_idx);
            end
            @(negedge clk);
            // Tail cycles follow the last redirect, stale slots are long gone
            assert (!jumping_o) else begin
                errors++;
                $display("ERROR %0t: jumping still high at end of run", $time);
            end
            if (checks < MIN_CHECKS) begin
                $display("Too few valid outputs were checked: %0d", checks);
            end
            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0 && checks >= MIN_CHECKS) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    // Stimulus length plus reset plus margin
    initial begin
        wait (stim_ready);
        #((RESET_CYC + stim_cycles + 100) * CLK_PERIOD);
        $display("Watchdog timeout, the run did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: verilog/fetch_top.sv
/*
 * Fetch front end top level. Joins the redirect control, the address
 * register and the output stage. Memory answers one clock after the address.
 */

`timescale 1ns/1ps

`include "ifetch_consts.svh"

module fetch_top
    import ifetch_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      sys_reset_i,
    input  logic                      enable_i,
    input  logic                      jump_i,
    input  logic [`IFETCH_ADDR_W-1:0] jump_target_i,
    input  logic [`IFETCH_ADDR_W-1:0] mtvec_i,
    input  logic [`IFETCH_ADDR_W-1:0] mepc_i,
    input  logic                      exception_i,
    input  logic                      interrupt_ack_i,
    input  logic                      mret_i,
    input  logic [31:0]               instr_data_i,
    output logic [`IFETCH_ADDR_W-1:0] instr_addr_o,
    output logic                      jumping_o,
    output fetch_out_t                fetch_o
);

    // Control to datapath
    redirect_t                redirect;
    logic                     jumped_r2;
    logic [`IFETCH_TAG_W-1:0] tag;

    fetch_ctrl i_fetch_ctrl (
        .clk             (clk),
        .reset_n         (reset_n),
        .sys_reset_i     (sys_reset_i),
        .enable_i        (enable_i),
        .jump_i          (jump_i),
        .jump_target_i   (jump_target_i),
        .mtvec_i         (mtvec_i),
        .mepc_i          (mepc_i),
        .exception_i     (exception_i),
        .interrupt_ack_i (interrupt_ack_i),
        .mret_i          (mret_i),
        .redirect_o      (redirect),
        .jumping_o       (jumping_o),
        .jumped_r2_o     (jumped_r2),
        .tag_o           (tag)
    );

    fetch_addr i_fetch_addr (
        .clk          (clk),
        .reset_n      (reset_n),
        .sys_reset_i  (sys_reset_i),
        .enable_i     (enable_i),
        .redirect_i   (redirect),
        .instr_addr_o (instr_addr_o)
    );

    fetch_data i_fetch_data (
        .clk          (clk),
        .reset_n      (reset_n),
        .sys_reset_i  (sys_reset_i),
        .enable_i     (enable_i),
        .redirect_i   (redirect),
        .jumped_r2_i  (jumped_r2),
        .tag_i        (tag),
        .instr_data_i (instr_data_i),
        .fetch_o      (fetch_o)
    );

endmodule

// File: fetch/fetch_data.sv
/*
 * Fetch output stage. Holds the memory word across a stall and registers
 * the instruction, its PC and its tag for decode.
 */

`timescale 1ns/1ps

`include "ifetch_consts.svh"

module fetch_data
    import ifetch_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     sys_reset_i,
    input  logic                     enable_i,
    input  redirect_t                redirect_i,
    input  logic                     jumped_r2_i,
    input  logic [`IFETCH_TAG_W-1:0] tag_i,
    input  logic [31:0]              instr_data_i,
    output fetch_out_t               fetch_o
);

    logic                      enable_r;
    logic [31:0]               instr_held;
    logic [31:0]               instr_fetched;
    logic [`IFETCH_ADDR_W-1:0] target_q;
    logic [`IFETCH_ADDR_W-1:0] pc_next;
    fetch_out_t                fetch_next;

    //////////////////////////////////////////////////////////////////////
    // Stall hold
    //////////////////////////////////////////////////////////////////////

    // Enable seen on the last edge
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            enable_r <= 1'b0;
        end else begin
            enable_r <= enable_i;
        end
    end

    // First stalled cycle still carries a live word, keep it
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instr_held <= `IFETCH_NOP;
        end else if (!enable_i && enable_r) begin
            instr_held <= instr_data_i;
        end
    end

    // Right after a stall the memory bus is one word ahead
    assign instr_fetched = enable_r ? instr_data_i : instr_held;

    //////////////////////////////////////////////////////////////////////
    // PC tracking
    //////////////////////////////////////////////////////////////////////

    // Redirect target, word aligned like the fetch address
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            target_q <= `IFETCH_START_ADDR;
        end else if (sys_reset_i) begin
            target_q <= `IFETCH_START_ADDR;
        end else if (redirect_i.kind != NONE) begin
            target_q <= {redirect_i.target[`IFETCH_ADDR_W-1:2], 2'b00};
        end
    end

    // Target slot reaches the output, else sequential
    assign pc_next = jumped_r2_i ? target_q : (fetch_o.pc + `IFETCH_ADDR_W'(4));

    //////////////////////////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        fetch_next.instr = instr_fetched;
        fetch_next.pc    = pc_next;
        fetch_next.tag   = tag_i;
    end

    // Moves only on enabled edges
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetch_o.instr <= `IFETCH_NOP;
            fetch_o.pc    <= '0;
            fetch_o.tag   <= '1;
        end else if (enable_i) begin
            fetch_o <= fetch_next;
        end
    end

    // Redirect and sequential paths both keep word alignment
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (!reset_n)
        fetch_o.pc[1:0] == 2'b00
    );

endmodule

// File: fetch/fetch_addr.sv
/*
 * Instruction address register. Loads a redirect target, advances by
 * four while enabled, and holds otherwise.
 */

`timescale 1ns/1ps

`include "ifetch_consts.svh"

module fetch_addr
    import ifetch_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      sys_reset_i,
    input  logic                      enable_i,
    input  redirect_t                 redirect_i,
    output logic [`IFETCH_ADDR_W-1:0] instr_addr_o
);

    logic [`IFETCH_ADDR_W-1:0] addr_plus4;
    logic [`IFETCH_ADDR_W-1:0] addr_next;

    assign addr_plus4 = instr_addr_o + `IFETCH_ADDR_W'(4);

    //////////////////////////////////////////////////////////////////////
    // Next address
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        if (redirect_i.kind != NONE) begin
            // Redirect wins even when stalled
            addr_next = {redirect_i.target[`IFETCH_ADDR_W-1:2], 2'b00};
        end else if (enable_i) begin
            addr_next = addr_plus4;
        end else begin
            // Stall, keep presenting the same word
            addr_next = instr_addr_o;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            instr_addr_o <= `IFETCH_START_ADDR;
        end else if (sys_reset_i) begin
            instr_addr_o <= `IFETCH_START_ADDR;
        end else begin
            instr_addr_o <= addr_next;
        end
    end

    // Memory only sees word fetches
    a_addr_aligned: assert property (
        @(posedge clk) disable iff (!reset_n)
        instr_addr_o[1:0] == 2'b00
    );

endmodule

// File: fetch/fetch_ctrl.sv
/*
 * Fetch control: picks the redirect by priority, marks stale fetch slots
 * with the jumping flag and counts redirects into a tag.
 */

`timescale 1ns/1ps

`include "ifetch_consts.svh"

module fetch_ctrl
    import ifetch_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      sys_reset_i,
    input  logic                      enable_i,
    input  logic                      jump_i,
    input  logic [`IFETCH_ADDR_W-1:0] jump_target_i,
    input  logic [`IFETCH_ADDR_W-1:0] mtvec_i,
    input  logic [`IFETCH_ADDR_W-1:0] mepc_i,
    input  logic                      exception_i,
    input  logic                      interrupt_ack_i,
    input  logic                      mret_i,
    output redirect_t                 redirect_o,
    output logic                      jumping_o,
    output logic                      jumped_r2_o,
    output logic [`IFETCH_TAG_W-1:0]  tag_o
);

    //////////////////////////////////////////////////////////////////////
    // Redirect priority
    //////////////////////////////////////////////////////////////////////

    logic                     jumped;
    logic                     jumped_r;
    logic [`IFETCH_TAG_W-1:0] tag_cnt;

    always_comb begin
        // Machine return first
        if (mret_i) begin
            redirect_o.kind   = MRET;
            redirect_o.target = mepc_i;
        end else if (exception_i || interrupt_ack_i) begin
            // Trap entry, exception and interrupt share mtvec
            redirect_o.kind   = TRAP;
            redirect_o.target = mtvec_i;
        end else if (jump_i) begin
            redirect_o.kind   = JUMP;
            redirect_o.target = jump_target_i;
        end else begin
            redirect_o.kind   = NONE;
            redirect_o.target = jump_target_i;
        end
    end

    assign jumped = (redirect_o.kind != NONE);

    //////////////////////////////////////////////////////////////////////
    // Stale slot tracking
    //////////////////////////////////////////////////////////////////////

    // Redirect seen, cleared by the next enabled edge
    // Restart counts as a redirect here, without a tag step
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r <= 1'b1;
        end else if (jumped || sys_reset_i) begin
            jumped_r <= 1'b1;
        end else if (enable_i) begin
            jumped_r <= 1'b0;
        end
    end

    // Second stage, lines up with the data of the redirect target
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumped_r2_o <= 1'b1;
        end else if (enable_i) begin
            jumped_r2_o <= jumped_r;
        end
    end

    // High over the two slots already in flight
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            jumping_o <= 1'b1;
        end else if (jumped || jumped_r || sys_reset_i) begin
            jumping_o <= 1'b1;
        end else if (enable_i) begin
            jumping_o <= 1'b0;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Tag counter
    //////////////////////////////////////////////////////////////////////

    // One step per redirect, free to wrap
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_cnt <= '0;
        end else if (jumped) begin
            tag_cnt <= tag_cnt + `IFETCH_TAG_W'(1);
        end
    end

    // First delay stage, the data stage adds the second
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            tag_o <= '1;
        end else if (enable_i) begin
            tag_o <= tag_cnt;
        end
    end

    // A redirect keeps the flag up over both slots already in flight
    a_jump_flag: assert property (
        @(posedge clk) disable iff (!reset_n)
        ($past(jumped) || $past(jumped, 2)) |-> jumping_o
    );

endmodule

// File: common/ifetch_pkg.sv
/*
 * Types shared by the fetch control, address and data modules.
 * Import with a wildcard in the module header.
 */

`include "ifetch_consts.svh"

package ifetch_pkg;

    //////////////////////////////////////////////////////////////////////
    // Redirect selection
    //////////////////////////////////////////////////////////////////////

    // Kind of redirect chosen this cycle, MRET wins over TRAP over JUMP
    typedef enum logic [1:0] {
        NONE = 2'd0,
        JUMP = 2'd1,
        TRAP = 2'd2,
        MRET = 2'd3
    } redirect_kind_e;

    // Chosen redirect, target not yet aligned
    typedef struct packed {
        redirect_kind_e            kind;
        logic [`IFETCH_ADDR_W-1:0] target;
    } redirect_t;

    //////////////////////////////////////////////////////////////////////
    // Fetch stage output
    //////////////////////////////////////////////////////////////////////

    // Instruction to decode, with its PC and redirect tag
    typedef struct packed {
        logic [31:0]               instr;
        logic [`IFETCH_ADDR_W-1:0] pc;
        logic [`IFETCH_TAG_W-1:0]  tag;
    } fetch_out_t;

endpackage

// File: common/ifetch_consts.svh
/*
 * Shared constants for the instruction fetch front end.
 * Include this where widths, the start address or the NOP word are needed.
 */

`ifndef IFETCH_CONSTS_SVH
`define IFETCH_CONSTS_SVH

// Address loaded by reset_n and by sys_reset
`define IFETCH_START_ADDR 32'h0000_0100

// addi x0, x0, 0
`define IFETCH_NOP 32'h0000_0013

// Redirect tag width, wraps modulo 8
`define IFETCH_TAG_W 3

// Instruction address and PC width
`define IFETCH_ADDR_W 32

`endif
